/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen      = 32;  // data and address width
  localparam int reg_idx_w = 5;   // register index width
  localparam int num_regs  = 32;  // x0 included

  localparam logic [xlen-1:0] reset_pc    = 32'h0000_0000;
  localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;  // the only system word accepted

  // major opcodes of the instruction word, bits [6:0]
  typedef enum logic [6:0] {
    opc_reg    = 7'b0110011,
    opc_imm    = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_system = 7'b1110011
  } opcode_e;

  // operations the core executes
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_lui,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_ebreak,
    op_illegal
  } op_e;

  typedef struct packed {
    op_e                  op;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [xlen-1:0]      imm;        // sign-extended
    logic                 use_imm;    // second operand is imm
    logic                 writes_rd;
  } dec_t;

  typedef struct packed {
    logic [xlen-1:0] wdata;   // write-back value
    logic            taken;   // jump or branch taken
    logic [xlen-1:0] target;
  } exec_t;

  typedef struct packed {
    logic [xlen-1:0]      pc;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      wdata;
    logic                 wen;
  } retire_t;

endpackage

`default_nettype wire

/* src/rv_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_decoder import rv_pkg::*; (
  input  logic [xlen-1:0] inst,
  output dec_t            dec
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_b;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  // funct3 to operation, shared by the register and immediate forms
  function automatic op_e arith_op(input logic [2:0] f3);
    op_e op;
    case (f3)
      3'b000:  op = op_add;
      3'b010:  op = op_slt;
      3'b100:  op = op_xor;
      3'b110:  op = op_or;
      3'b111:  op = op_and;
      default: op = op_illegal;  // shifts and sltu not supported
    endcase
    return op;
  endfunction

  always_comb begin
    dec     = '0;
    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.op  = op_illegal;

    case (opcode)
      opc_reg: begin
        if (funct7 == 7'b0000000) begin
          dec.op = arith_op(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.op = op_sub;
        end
      end

      opc_imm: begin
        dec.op      = arith_op(funct3);
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
      end

      opc_lui: begin
        dec.op      = op_lui;
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
      end

      opc_jal: begin
        dec.op      = op_jal;
        dec.imm     = imm_j;
        dec.use_imm = 1'b1;
      end

      opc_jalr: begin
        if (funct3 == 3'b000) begin
          dec.op = op_jalr;
        end
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;  // adder forms rs1 + imm
      end

      opc_branch: begin
        case (funct3)
          3'b000:  dec.op = op_beq;
          3'b001:  dec.op = op_bne;
          default: dec.op = op_illegal;
        endcase
        dec.imm = imm_b;     // compare uses rs2, so use_imm stays low
      end

      opc_system: begin
        if (inst == ebreak_word) begin
          dec.op = op_ebreak;
        end
      end

      default: begin
        dec.op = op_illegal;
      end
    endcase

    // branches, ebreak and illegal words leave the register file alone
    case (dec.op)
      op_beq, op_bne, op_ebreak, op_illegal: dec.writes_rd = 1'b0;
      default:                               dec.writes_rd = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* src/rv_reg_file.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_reg_file import rv_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [reg_idx_w-1:0] rs1,
  input  logic [reg_idx_w-1:0] rs2,
  output logic [xlen-1:0]      rdata_1,
  output logic [xlen-1:0]      rdata_2,
  input  logic                 wen,
  input  logic [reg_idx_w-1:0] rd,
  input  logic [xlen-1:0]      wdata
);

  logic [xlen-1:0] regs [1:num_regs-1];  // x0 has no storage

  // no bypass, a write shows up on the next cycle
  always_comb begin
    rdata_1 = '0;
    rdata_2 = '0;
    if (rs1 != '0) begin
      rdata_1 = regs[rs1];
    end
    if (rs2 != '0) begin
      rdata_2 = regs[rs2];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* src/rv_exec.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_exec import rv_pkg::*; (
  input  dec_t            dec,
  input  logic [xlen-1:0] rdata_1,
  input  logic [xlen-1:0] rdata_2,
  input  logic [xlen-1:0] pc,
  output exec_t           result
);

  logic [xlen-1:0] operand_2;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic [xlen-1:0] alu_out;
  logic [xlen-1:0] pc_plus_4;
  logic [xlen-1:0] pc_plus_imm;
  logic            less;
  logic            equal;

  assign operand_2 = dec.use_imm ? dec.imm : rdata_2;

  assign sum  = rdata_1 + operand_2;  // also the jalr target
  assign diff = rdata_1 - operand_2;
  assign less = $signed(rdata_1) < $signed(operand_2);

  assign equal = (rdata_1 == rdata_2);  // branches always compare two registers

  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + dec.imm;

  always_comb begin
    case (dec.op)
      op_add:          alu_out = sum;
      op_sub:          alu_out = diff;
      op_and:          alu_out = rdata_1 & operand_2;
      op_or:           alu_out = rdata_1 | operand_2;
      op_xor:          alu_out = rdata_1 ^ operand_2;
      op_slt:          alu_out = {{(xlen-1){1'b0}}, less};
      op_lui:          alu_out = dec.imm;
      op_jal, op_jalr: alu_out = pc_plus_4;  // link address
      default:         alu_out = '0;
    endcase
  end

  always_comb begin
    result.wdata = alu_out;

    case (dec.op)
      op_jal:  result.taken = 1'b1;
      op_jalr: result.taken = 1'b1;
      op_beq:  result.taken = equal;
      op_bne:  result.taken = !equal;
      default: result.taken = 1'b0;
    endcase

    if (dec.op == op_jalr) begin
      result.target = {sum[xlen-1:1], 1'b0};  // bit 0 cleared
    end else begin
      result.target = pc_plus_imm;
    end
  end

endmodule

`default_nettype wire

/* src/rv_pc.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_pc import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            advance,
  input  op_e             op,
  input  exec_t           result,
  output logic [xlen-1:0] current_pc,
  output logic [xlen-1:0] next_pc,
  output logic            halted,
  output logic            illegal
);

  assign next_pc = result.taken ? result.target : current_pc + 32'd4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      current_pc <= reset_pc;
    end else if (advance) begin
      current_pc <= next_pc;
    end
  end

  // sticky status, cleared only by reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (advance) begin
      if (op == op_ebreak) begin
        halted <= 1'b1;
      end
      if (op == op_illegal) begin
        halted  <= 1'b1;
        illegal <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/rv_core.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [xlen-1:0] inst,
  input  logic            inst_valid,

  output logic [xlen-1:0] current_pc,
  output logic [xlen-1:0] next_pc,
  output logic            retire_valid,
  output retire_t         retire,
  output logic            halted,
  output logic            illegal
);

  dec_t            dec;
  exec_t           ex;
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic            advance;
  logic            reg_wen;

  assign advance = inst_valid && !halted;  // strobes are dropped once halted
  assign reg_wen = advance && dec.writes_rd && (dec.rd != '0);

  rv_decoder u_decoder (
    .inst ( inst ),
    .dec  ( dec  )
  );

  // register reads run off the raw inst fields, beside the decoder
  rv_reg_file u_reg_file (
    .clk     ( clk          ),
    .rst_n   ( rst_n        ),
    .rs1     ( inst[19:15]  ),
    .rs2     ( inst[24:20]  ),
    .rdata_1 ( rdata_1      ),
    .rdata_2 ( rdata_2      ),
    .wen     ( reg_wen      ),
    .rd      ( dec.rd       ),
    .wdata   ( ex.wdata     )
  );

  rv_exec u_exec (
    .dec     ( dec        ),
    .rdata_1 ( rdata_1    ),
    .rdata_2 ( rdata_2    ),
    .pc      ( current_pc ),
    .result  ( ex         )
  );

  rv_pc u_pc (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .advance    ( advance    ),
    .op         ( dec.op     ),
    .result     ( ex         ),
    .current_pc ( current_pc ),
    .next_pc    ( next_pc    ),
    .halted     ( halted     ),
    .illegal    ( illegal    )
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= advance;  // one pulse per accepted strobe
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      retire.pc    <= current_pc;
      retire.rd    <= dec.rd;
      retire.wdata <= ex.wdata;
      retire.wen   <= reg_wen;
    end
  end

endmodule

`default_nettype wire

/* tb/rv_iss.sv */
`default_nettype none

package rv_iss;

  import rv_pkg::*;

  typedef struct packed {
    logic            accepted;  // low once the model has halted
    retire_t         rec;
    logic [xlen-1:0] pc_after;
    logic            halted;
    logic            illegal;
  } expect_t;

  logic [xlen-1:0] arch_regs [num_regs];
  logic [xlen-1:0] arch_pc;
  logic            arch_halted;
  logic            arch_illegal;

  function automatic void reset_model();
    for (int i = 0; i < num_regs; i++) begin
      arch_regs[i] = '0;
    end
    arch_pc      = reset_pc;
    arch_halted  = 1'b0;
    arch_illegal = 1'b0;
  endfunction

  // runs one word on the architectural state and predicts its retire record
  function automatic expect_t execute_word(input logic [xlen-1:0] w);
    expect_t         e;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] val;
    logic [xlen-1:0] next;
    logic            writes;
    logic            bad;
    logic            stop;
    e = '0;
    if (arch_halted) begin
      return e;
    end
    a      = arch_regs[w[19:15]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    b      = w[5] ? arch_regs[w[24:20]] : imm_i;  // register forms have bit 5 set
    val    = '0;
    next   = arch_pc + 4;
    writes = 1'b1;
    bad    = 1'b0;
    stop   = 1'b0;
    case (w[6:0])
      7'b0110011, 7'b0010011: begin
        case (w[14:12])
          3'b000:  val = (w[5] && w[30]) ? a - b : a + b;
          3'b010:  val = {31'b0, $signed(a) < $signed(b)};
          3'b100:  val = a ^ b;
          3'b110:  val = a | b;
          3'b111:  val = a & b;
          default: bad = 1'b1;
        endcase
        // funct7 is zero, or selects sub
        if (w[5] && w[31:25] != 7'b0000000 && w[31:25] != 7'b0100000) begin
          bad = 1'b1;
        end
        if (w[5] && w[31:25] == 7'b0100000 && w[14:12] != 3'b000) begin
          bad = 1'b1;
        end
      end
      7'b0110111: val = {w[31:12], 12'b0};
      7'b1101111: begin
        val  = arch_pc + 4;
        next = arch_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        val  = arch_pc + 4;
        next = (a + imm_i) & ~32'd1;
        bad  = (w[14:12] != 3'b000);
      end
      7'b1100011: begin
        writes = 1'b0;
        bad    = (w[14:13] != 2'b00);
        if ((a == b) != w[12]) begin  // beq on equal, bne on not equal
          next = arch_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b1110011: begin
        writes = 1'b0;
        stop   = 1'b1;
        bad    = (w != 32'h0010_0073);
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      writes = 1'b0;
      next   = arch_pc + 4;
    end
    e.accepted  = 1'b1;
    e.rec.pc    = arch_pc;
    e.rec.rd    = w[11:7];
    e.rec.wen   = writes && (w[11:7] != 5'd0);
    e.rec.wdata = e.rec.wen ? val : '0;
    if (e.rec.wen) begin
      arch_regs[w[11:7]] = val;
    end
    arch_pc      = next;
    arch_halted  = arch_halted || stop || bad;
    arch_illegal = arch_illegal || bad;
    e.pc_after   = arch_pc;
    e.halted     = arch_halted;
    e.illegal    = arch_illegal;
    return e;
  endfunction

endpackage

`default_nettype wire

/* tb/rv_core_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*, rv_iss::*; ();

  localparam int alu_count     = 400;
  localparam int flow_count    = 100;
  localparam int chain_count   = 30;
  localparam int total_strobes = 1 + alu_count + 2 * flow_count + chain_count + 1 + 22;
  localparam int cycle_limit   = 2 * total_strobes + 200;

  logic            clk = 1'b0;
  logic            rst_n;
  logic [xlen-1:0] inst;
  logic            inst_valid;
  logic [xlen-1:0] current_pc;
  logic [xlen-1:0] next_pc;
  logic            retire_valid;
  retire_t         retire;
  logic            halted;
  logic            illegal;

  integer  seed      = 70094;
  int      errors    = 0;
  int      cycles    = 0;
  string   test_name = "reset";
  expect_t exp_q [$];  // predicted records, oldest first

  always #4 clk = ~clk;

  rv_core rv_core_i (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .inst         ( inst         ),
    .inst_valid   ( inst_valid   ),
    .current_pc   ( current_pc   ),
    .next_pc      ( next_pc      ),
    .retire_valid ( retire_valid ),
    .retire       ( retire       ),
    .halted       ( halted       ),
    .illegal      ( illegal      )
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles in test %s, errors: %0d", cycles, test_name,
               errors + 1);
      $display("Test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input logic [xlen-1:0] expected,
                                 input logic [xlen-1:0] actual);
    $display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    errors++;
  endtask

  // retire records are compared mid-cycle, away from the clock edge
  always @(negedge clk) begin : monitor
    expect_t e;
    if (rst_n === 1'b1 && retire_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("unexpected retire_valid in test %s at pc %h", test_name, retire.pc);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (retire.pc !== e.rec.pc) report_mismatch("pc", e.rec.pc, retire.pc);
        if (retire.rd !== e.rec.rd) report_mismatch("rd", e.rec.rd, retire.rd);
        if (retire.wen !== e.rec.wen) report_mismatch("wen", e.rec.wen, retire.wen);
        if (e.rec.wen && retire.wdata !== e.rec.wdata) begin
          report_mismatch("wdata", e.rec.wdata, retire.wdata);
        end
        if (current_pc !== e.pc_after) report_mismatch("current_pc", e.pc_after, current_pc);
        if (halted !== e.halted) report_mismatch("halted", e.halted, halted);
        if (illegal !== e.illegal) report_mismatch("illegal", e.illegal, illegal);
      end
    end
  end

  task automatic apply_reset();
    rst_n      <= 1'b0;
    inst_valid <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_model();
  endtask

  task automatic strobe(input logic [xlen-1:0] w);
    expect_t e;
    @(posedge clk);
    inst       <= w;
    inst_valid <= 1'b1;
    e = execute_word(w);
    if (e.accepted) exp_q.push_back(e);
    @(negedge clk);
    // next_pc follows the word still on inst
    if (e.accepted && next_pc !== e.pc_after) begin
      report_mismatch("next_pc", e.pc_after, next_pc);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      inst_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    idle(3);
    if (exp_q.size() != 0) begin
      $display("retire_valid missing for %0d instructions in test %s", exp_q.size(), test_name);
      errors++;
      exp_q.delete();
    end
  endtask

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [2:0] arith_f3(input int k);
    case (k)
      0:       return 3'b000;
      1:       return 3'b010;
      2:       return 3'b100;
      3:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic logic [xlen-1:0] alu_word();
    logic [xlen-1:0] r;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [6:0]      f7;
    logic [2:0]      f3;
    int              k;
    r   = $random(seed);
    rd  = pick(8);  // small register set keeps dependencies frequent
    rs1 = pick(8);
    rs2 = pick(8);
    k   = pick(6);
    f7  = (k == 5) ? 7'b0100000 : 7'b0;  // k of 5 selects sub
    f3  = (k == 5) ? 3'b000 : arith_f3(k);
    case (pick(3))
      0:       return {f7, rs2, rs1, f3, rd, 7'b0110011};
      1:       return {r[31:20], rs1, arith_f3(pick(5)), rd, 7'b0010011};
      default: return {r[31:12], rd, 7'b0110111};
    endcase
  endfunction

  function automatic logic [xlen-1:0] flow_word();
    logic [xlen-1:0] r;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    r   = $random(seed);
    rd  = pick(8);
    rs1 = pick(8);
    rs2 = pick(8);
    case (pick(4))
      0:       return {r[31:12], rd, 7'b1101111};
      1:       return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
      2:       return {r[31:25], rs2, rs1, 3'b000, r[11:7], 7'b1100011};
      default: return {r[31:25], rs2, rs1, 3'b001, r[11:7], 7'b1100011};
    endcase
  endfunction

  function automatic logic [xlen-1:0] illegal_word();
    logic [xlen-1:0] w;
    w = $random(seed);
    while (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011 || w[6:0] == 7'b0110111 ||
           w[6:0] == 7'b1101111 || w[6:0] == 7'b1100111 || w[6:0] == 7'b1100011 ||
           w[6:0] == 7'b1110011) begin
      w = $random(seed);
    end
    return w;
  endfunction

  initial begin
    logic [4:0] prev;
    logic [4:0] rd;
    rst_n      <= 1'b0;
    inst       <= '0;
    inst_valid <= 1'b0;
    apply_reset();
    @(negedge clk);
    if (current_pc !== reset_pc) report_mismatch("current_pc", reset_pc, current_pc);
    if (halted !== 1'b0 || illegal !== 1'b0 || retire_valid !== 1'b0) begin
      $display("status outputs are not low after reset");
      errors++;
    end
    strobe({7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011});  // add x3, x1, x2
    drain();

    test_name = "alu";
    for (int i = 0; i < alu_count; i++) begin
      strobe(alu_word());
      idle(pick(3));
    end
    drain();

    test_name = "control";
    for (int i = 0; i < flow_count; i++) begin
      strobe(flow_word());
      strobe(alu_word());
    end
    drain();

    test_name = "chain";
    prev = 5'd1;
    strobe({12'h5a3, 5'd0, 3'b000, prev, 7'b0010011});
    for (int i = 0; i < chain_count; i++) begin
      rd = pick(7) + 1;
      if (pick(2) == 0) strobe({12'(pick(4096)), prev, 3'b000, rd, 7'b0010011});
      else strobe({7'b0, 5'(pick(8)), prev, arith_f3(pick(5)), rd, 7'b0110011});
      prev = rd;
    end
    drain();

    test_name = "ebreak";
    strobe(ebreak_word);
    idle(2);
    @(negedge clk);
    if (halted !== 1'b1) begin
      $display("halted is not set after ebreak");
      errors++;
    end
    repeat (10) strobe(alu_word());
    drain();
    @(negedge clk);
    if (current_pc !== arch_pc) report_mismatch("current_pc", arch_pc, current_pc);

    test_name = "illegal";
    apply_reset();
    strobe(illegal_word());
    idle(2);
    @(negedge clk);
    if (illegal !== 1'b1 || halted !== 1'b1) begin
      $display("illegal and halted are not both set after an unsupported word");
      errors++;
    end
    repeat (10) strobe(alu_word());
    drain();
    @(negedge clk);
    if (current_pc !== arch_pc) report_mismatch("current_pc", arch_pc, current_pc);

    $display("run complete after %0d cycles, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_reg_file.sv
src/rv_exec.sv
src/rv_pc.sv
src/rv_core.sv
tb/rv_iss.sv
tb/rv_core_tb.sv
